//--- src/arb_settings.svh
// Channel count is expected to be 2 or more; no range check is made
// Values are fixed at build time and apply to every arbiter instance

`ifndef ARB_SETTINGS_SVH
`define ARB_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Arbiter sizing
//////////////////////////////////////////////////////////////////////

`define ARB_NUM_CH 4      // Number of request channels
`define ARB_DATA_W 16     // Payload width in bits

//////////////////////////////////////////////////////////////////////
// Priority direction
//////////////////////////////////////////////////////////////////////

// 0 gives channel 0 the win, 1 gives the top channel the win
`define ARB_HIGH_PRIO 0

`endif

//--- src/arb_pkg.sv
// Shared types for the stream arbiter
// Widths follow the settings header

`default_nettype none

`include "arb_settings.svh"

package arb_pkg;

  //////////////////////////////////////////////////////////////////////
  // Payload and addressing types
  //////////////////////////////////////////////////////////////////////

  // One payload word
  typedef logic [`ARB_DATA_W-1:0] data_t;

  // Channel index, wide enough for ARB_NUM_CH channels
  typedef logic [$clog2(`ARB_NUM_CH)-1:0] chan_t;

  // One bit per channel
  typedef logic [`ARB_NUM_CH-1:0] mask_t;  // Request and grant masks

endpackage

`default_nettype wire

//--- src/encoder.sv
// Input must be one-hot or all zero; several set bits give an OR of their indices
// NUM_WIRE of 2 or more

`timescale 1ns/1ps
`default_nettype none

module encoder #(
  parameter int NUM_WIRE = 4  // Width of the one-hot input
) (
  input  logic [        NUM_WIRE-1:0] d_i,          // One-hot request
  output logic [$clog2(NUM_WIRE)-1:0] addr_o,       // Binary index of set bit
  output logic                        addr_valid_o  // Any bit set
);

  localparam int ADDR_W = $clog2(NUM_WIRE);

  //////////////////////////////////////////////////////////////////////
  // Index OR tree
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    addr_o = '0;
    for (int i = 0; i < NUM_WIRE; i++) begin
      if (d_i[i]) begin
        addr_o = addr_o | ADDR_W'(i);  // Only one term expected
      end
    end
  end

  assign addr_valid_o = |d_i;  // Some request present

endmodule

`default_nettype wire

//--- src/priority_encoder.sv
// Fixed priority pick among NUM_WIRE requests, then binary encode
// Lowest index wins unless HIGH_INDEX_PRIORITY is set

`timescale 1ns/1ps
`default_nettype none

module priority_encoder #(
  parameter int NUM_WIRE            = 4,  // Request count
  parameter bit HIGH_INDEX_PRIORITY = 0   // 1 favours the top index
) (
  input  logic [        NUM_WIRE-1:0] d_i,          // Raw requests
  output logic [$clog2(NUM_WIRE)-1:0] addr_o,       // Winner index
  output logic                        addr_valid_o  // Winner exists
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  logic [NUM_WIRE-1:0] found_before;  // A favoured request lies ahead
  logic [NUM_WIRE-1:0] survivor;      // Single remaining request

  //////////////////////////////////////////////////////////////////////
  // Found chain
  //////////////////////////////////////////////////////////////////////

  if (HIGH_INDEX_PRIORITY) begin : g_from_top
    // Chain walks down from the top bit
    assign found_before[NUM_WIRE-1] = 1'b0;
    for (genvar i = NUM_WIRE - 2; i >= 0; i--) begin : g_chain
      assign found_before[i] = found_before[i+1] | d_i[i+1];
    end
  end else begin : g_from_bottom
    // Chain walks up from bit 0
    assign found_before[0] = 1'b0;
    for (genvar i = 1; i < NUM_WIRE; i++) begin : g_chain
      assign found_before[i] = found_before[i-1] | d_i[i-1];
    end
  end

  // Clear everything behind the first hit
  assign survivor = d_i & ~found_before;

  //////////////////////////////////////////////////////////////////////
  // Encode
  //////////////////////////////////////////////////////////////////////

  encoder #(
    .NUM_WIRE(NUM_WIRE)
  ) u_encoder (
    .d_i         (survivor),
    .addr_o      (addr_o),
    .addr_valid_o(addr_valid_o)
  );

endmodule

`default_nettype wire

//--- src/chan_ingress.sv
// One-entry holding slot per channel; grant_i must only hit a full slot
// Ready depends on grant_i in the same cycle

`timescale 1ns/1ps
`default_nettype none

`include "arb_settings.svh"

module chan_ingress (
  input  logic                                  clk_i,
  input  logic                                  reset_i,      // Sync, active high
  input  arb_pkg::mask_t                        in_valid_i,   // Per channel valid
  input  arb_pkg::data_t [`ARB_NUM_CH-1:0]      in_data_i,    // Per channel word
  input  arb_pkg::mask_t                        grant_i,      // One-hot release
  output arb_pkg::mask_t                        in_ready_o,   // Per channel ready
  output arb_pkg::mask_t                        held_mask_o,  // Full slots
  output arb_pkg::data_t [`ARB_NUM_CH-1:0]      held_data_o   // Slot contents
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  arb_pkg::mask_t                   slot_full;  // Full flag per slot
  arb_pkg::mask_t                   load_mask;  // Input transfer this cycle
  arb_pkg::data_t [`ARB_NUM_CH-1:0] slot_data;  // Word storage

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  // Empty slot or slot leaving this cycle can take a word
  assign in_ready_o = ~slot_full | grant_i;

  assign load_mask  = in_valid_i & in_ready_o;  // Accepted words

  //////////////////////////////////////////////////////////////////////
  // Full flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_full <= '0;  // All empty
    end else begin
      // Stay full unless granted; a reload keeps it full
      slot_full <= load_mask | (slot_full & ~grant_i);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Word storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int c = 0; c < `ARB_NUM_CH; c++) begin
      if (load_mask[c]) begin
        slot_data[c] <= in_data_i[c];  // Capture on transfer
      end
    end
  end

  // Outputs
  assign held_mask_o = slot_full;
  assign held_data_o = slot_data;

endmodule

`default_nettype wire

//--- src/egress_register.sv
// One-deep output stage; loads are ignored when it has no room
// Word and channel stay put while out_ready_i is low

`timescale 1ns/1ps
`default_nettype none

module egress_register (
  input  logic           clk_i,
  input  logic           reset_i,      // Sync, active high
  input  logic           load_valid_i, // Granted word available
  input  arb_pkg::data_t load_data_i,  // Granted word
  input  arb_pkg::chan_t load_chan_i,  // Source channel
  output logic           room_o,       // Can accept this cycle
  output logic           out_valid_o,
  input  logic           out_ready_i,
  output arb_pkg::data_t out_data_o,
  output arb_pkg::chan_t out_chan_o
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  logic load_en;  // Actual load this cycle

  // Empty, or being drained right now
  assign room_o  = ~out_valid_o | out_ready_i;
  assign load_en = load_valid_i & room_o;

  //////////////////////////////////////////////////////////////////////
  // Valid flag
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_o <= 1'b0;
    end else if (load_en) begin
      out_valid_o <= 1'b1;  // New word, possibly back to back
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;  // Drained with nothing behind it
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (load_en) begin
      out_data_o <= load_data_i;
      out_chan_o <= load_chan_i;  // Tag travels with word
    end
  end

endmodule

`default_nettype wire

//--- src/prio_arbiter_top.sv
// Fixed priority stream arbiter with one holding slot per channel
// No fairness; a busy favoured channel starves the others

`timescale 1ns/1ps
`default_nettype none

`include "arb_settings.svh"

module prio_arbiter_top (
  input  logic                             clk_i,
  input  logic                             reset_i,     // Sync, active high
  input  arb_pkg::mask_t                   in_valid_i,  // Channel valids
  input  arb_pkg::data_t [`ARB_NUM_CH-1:0] in_data_i,   // Channel words
  output arb_pkg::mask_t                   in_ready_o,  // Channel readies
  output logic                             out_valid_o,
  input  logic                             out_ready_i,
  output arb_pkg::data_t                   out_data_o,
  output arb_pkg::chan_t                   out_chan_o   // Source of out_data_o
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  arb_pkg::mask_t                   held_mask;    // Full slots
  arb_pkg::data_t [`ARB_NUM_CH-1:0] held_data;    // Slot words
  arb_pkg::chan_t                   win_chan;     // Priority winner
  logic                             win_valid;    // Some slot full
  logic                             egress_room;  // Output can take a word
  logic                             load_valid;   // Winner moves this cycle
  arb_pkg::mask_t                   grant_mask;   // One-hot release

  //////////////////////////////////////////////////////////////////////
  // Input slots
  //////////////////////////////////////////////////////////////////////

  chan_ingress u_ingress (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .in_valid_i (in_valid_i),
    .in_data_i  (in_data_i),
    .grant_i    (grant_mask),
    .in_ready_o (in_ready_o),
    .held_mask_o(held_mask),
    .held_data_o(held_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Priority selection
  //////////////////////////////////////////////////////////////////////

  priority_encoder #(
    .NUM_WIRE           (`ARB_NUM_CH),
    .HIGH_INDEX_PRIORITY(`ARB_HIGH_PRIO)
  ) u_prio (
    .d_i         (held_mask),
    .addr_o      (win_chan),
    .addr_valid_o(win_valid)
  );

  // Grant only when the output stage can take the word
  assign load_valid = win_valid & egress_room;

  // Decode winner back to one-hot
  assign grant_mask = load_valid ? (arb_pkg::mask_t'(1) << win_chan) : '0;

  //////////////////////////////////////////////////////////////////////
  // Output stage
  //////////////////////////////////////////////////////////////////////

  egress_register u_egress (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .load_valid_i(load_valid),
    .load_data_i (held_data[win_chan]),  // Winning slot word
    .load_chan_i (win_chan),
    .room_o      (egress_room),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o),
    .out_chan_o  (out_chan_o)
  );

endmodule

`default_nettype wire

//--- test/prio_arbiter_tb.sv
// Vectors are written for 4 channels; only the priority sections mirror for high-index wins
// Output ready must end each section high or random so the drain can finish

`timescale 1ns/1ps
`default_nettype none

`include "arb_settings.svh"

module prio_arbiter_tb;

  localparam int VEC_DEPTH   = 512;  // Words in the vector image
  localparam int DRAIN_LIMIT = 400;  // Cycles allowed to empty a section
  localparam int CH_W        = $clog2(`ARB_NUM_CH);

  //////////////////////////////////////////////////////////////////////
  // DUT signals and state
  //////////////////////////////////////////////////////////////////////

  logic                             clk;
  logic                             reset;
  arb_pkg::mask_t                   in_valid;
  arb_pkg::data_t [`ARB_NUM_CH-1:0] in_data;
  arb_pkg::mask_t                   in_ready;
  logic                             out_valid;
  logic                             out_ready;
  arb_pkg::data_t                   out_data;
  arb_pkg::chan_t                   out_chan;

  logic [31:0]    vec_mem [VEC_DEPTH];
  arb_pkg::data_t pend_q [`ARB_NUM_CH][$];    // Words waiting per channel
  int             accept_q [`ARB_NUM_CH][$];  // Accept cycle per word
  int             inside_cnt [`ARB_NUM_CH];   // Accepted, not yet out
  arb_pkg::data_t exp_data_q[$];
  arb_pkg::chan_t exp_chan_q[$];
  arb_pkg::data_t got_data_q[$];
  arb_pkg::chan_t got_chan_q[$];
  int             got_lat_q[$];               // Accept to output edges

  logic [1:0]     ready_mode;  // 0 low, 1 high, 2 random
  logic           stall_prev;  // Output held under back-pressure
  arb_pkg::data_t prev_data;
  arb_pkg::chan_t prev_chan;
  int             cycle_cnt;
  int             sec_num;
  int             mismatch_errors;
  int             other_errors;

  always #4 clk = ~clk;  // 8 ns period

  prio_arbiter_top dut_i (
    .clk_i      (clk),
    .reset_i    (reset),
    .in_valid_i (in_valid),
    .in_data_i  (in_data),
    .in_ready_o (in_ready),
    .out_valid_o(out_valid),
    .out_ready_i(out_ready),
    .out_data_o (out_data),
    .out_chan_o (out_chan)
  );

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input arb_pkg::data_t exp,
                            input arb_pkg::data_t act);
    if (act !== exp) begin
      mismatch_errors++;
      $display("mismatch %s: data expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_chan(input string name, input arb_pkg::chan_t exp,
                            input arb_pkg::chan_t act);
    if (act !== exp) begin
      mismatch_errors++;
      $display("mismatch %s: channel expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_mask(input string name, input arb_pkg::mask_t exp,
                            input arb_pkg::mask_t act);
    if (act !== exp) begin
      mismatch_errors++;
      $display("mismatch %s: in_ready_o expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatch_errors++;
      $display("mismatch %s: out_valid_o expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp) begin
      mismatch_errors++;
      $display("mismatch %s: latency expected %0d actual %0d", name, exp, act);
    end
  endtask

  function automatic string section_name(input int sec);
    string s;
    case (sec)
      1:       s = "single_channel_latency";
      2:       s = "priority_order_all";
      3:       s = "priority_order_pair";
      4:       s = "priority_starvation";
      5:       s = "back_pressure";
      6:       s = "random_throttle";
      default: s = "unknown_section";
    endcase
    return s;
  endfunction

  function automatic int pending_total();
    int n;
    n = 0;
    for (int c = 0; c < `ARB_NUM_CH; c++) begin
      n += pend_q[c].size();
    end
    return n;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // One clock cycle of drive, sample and bookkeeping
  //////////////////////////////////////////////////////////////////////

  task automatic step_cycle();
    arb_pkg::mask_t                   valid_next;
    arb_pkg::data_t [`ARB_NUM_CH-1:0] data_next;
    arb_pkg::mask_t                   hs_mask;
    arb_pkg::mask_t                   ready_exp;
    arb_pkg::data_t                   smp_data;
    arb_pkg::chan_t                   smp_chan;
    logic                             out_hs;
    logic [31:0]                      rnd;
    int                               c;
    int                               held;
    valid_next = '0;
    data_next  = '0;
    for (c = 0; c < `ARB_NUM_CH; c++) begin
      if (pend_q[c].size() > 0) begin
        valid_next[c] = 1'b1;
        data_next[c]  = pend_q[c][0];  // Head stays until accepted
      end
    end
    in_valid <= valid_next;
    in_data  <= data_next;
    case (ready_mode)
      2'd0: out_ready <= 1'b0;
      2'd1: out_ready <= 1'b1;
      default: begin
        rnd = $urandom();
        out_ready <= rnd[0];
      end
    endcase
    @(negedge clk);  // Everything settled here
    hs_mask  = in_valid & in_ready;
    out_hs   = out_valid & out_ready;
    smp_data = out_data;
    smp_chan = out_chan;
    if (stall_prev) begin
      // Output must not move while stalled
      check_flag(section_name(sec_num), 1'b1, out_valid);
      check_data(section_name(sec_num), prev_data, out_data);
      check_chan(section_name(sec_num), prev_chan, out_chan);
    end
    if (out_valid === 1'b1 && out_ready === 1'b0) begin
      // No grant, so ready mirrors empty slots
      for (c = 0; c < `ARB_NUM_CH; c++) begin
        held = inside_cnt[c] - ((int'(out_chan) == c) ? 1 : 0);
        ready_exp[c] = (held <= 0);
      end
      check_mask(section_name(sec_num), ready_exp, in_ready);
    end
    stall_prev = out_valid & ~out_ready;
    prev_data  = out_data;
    prev_chan  = out_chan;
    @(posedge clk);
    cycle_cnt++;
    for (c = 0; c < `ARB_NUM_CH; c++) begin
      if (hs_mask[c]) begin
        void'(pend_q[c].pop_front());
        accept_q[c].push_back(cycle_cnt);
        inside_cnt[c]++;
      end
    end
    if (out_hs) begin
      got_data_q.push_back(smp_data);
      got_chan_q.push_back(smp_chan);
      if (accept_q[smp_chan].size() > 0) begin
        got_lat_q.push_back(cycle_cnt - accept_q[smp_chan].pop_front());
      end else begin
        got_lat_q.push_back(-1);  // Word never went in
      end
      inside_cnt[smp_chan]--;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Section drain and compare
  //////////////////////////////////////////////////////////////////////

  task automatic drain_section(output bit timed_out);
    int waited;
    waited    = 0;
    timed_out = 1'b0;
    while ((pending_total() > 0 || got_data_q.size() < exp_data_q.size()) && !timed_out) begin
      step_cycle();
      waited++;
      if (waited >= DRAIN_LIMIT) begin
        timed_out = 1'b1;
      end
    end
    if (!timed_out) begin
      repeat (4) step_cycle();  // Room for stray extra words
    end
  endtask

  task automatic compare_section(input int sec, input int order, input int lat);
    string          name;
    string          sub_name;
    arb_pkg::data_t exp_sub[$];
    arb_pkg::data_t got_sub[$];
    int             n;
    int             j;
    name = section_name(sec);
    if (got_data_q.size() != exp_data_q.size()) begin
      other_errors++;
      $display("%s: expected %0d output words but %0d came out", name,
               exp_data_q.size(), got_data_q.size());
    end
    n = (got_data_q.size() < exp_data_q.size()) ? got_data_q.size() : exp_data_q.size();
    if (order != 0) begin
      for (int k = 0; k < n; k++) begin
        // Order 2 mirrors when the top index wins
        j = (order == 2 && `ARB_HIGH_PRIO != 0) ? exp_data_q.size() - 1 - k : k;
        check_chan(name, exp_chan_q[j], got_chan_q[k]);
        check_data(name, exp_data_q[j], got_data_q[k]);
      end
    end else begin
      for (int c = 0; c < `ARB_NUM_CH; c++) begin
        exp_sub.delete();
        got_sub.delete();
        sub_name = $sformatf("%s ch%0d", name, c);
        for (int k = 0; k < exp_data_q.size(); k++) begin
          if (int'(exp_chan_q[k]) == c) exp_sub.push_back(exp_data_q[k]);
        end
        for (int k = 0; k < got_data_q.size(); k++) begin
          if (int'(got_chan_q[k]) == c) got_sub.push_back(got_data_q[k]);
        end
        if (exp_sub.size() != got_sub.size()) begin
          other_errors++;
          $display("%s: expected %0d words but %0d came out", sub_name,
                   exp_sub.size(), got_sub.size());
        end
        for (int k = 0; k < exp_sub.size() && k < got_sub.size(); k++) begin
          check_data(sub_name, exp_sub[k], got_sub[k]);
        end
      end
    end
    if (lat != 0) begin
      foreach (got_lat_q[k]) check_cycles(name, lat, got_lat_q[k]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  int             p;
  bit             running;
  bit             timed_out;
  logic [31:0]    kind;
  arb_pkg::mask_t new_mask;

  initial begin
    void'($urandom(32'h453f_0427));
    clk             = 1'b0;
    reset           = 1'b1;
    in_valid        = '0;
    in_data         = '0;
    out_ready       = 1'b0;
    ready_mode      = 2'd1;
    stall_prev      = 1'b0;
    prev_data       = '0;
    prev_chan       = '0;
    cycle_cnt       = 0;
    sec_num         = 1;
    mismatch_errors = 0;
    other_errors    = 0;
    foreach (inside_cnt[c]) inside_cnt[c] = 0;
    $readmemh("test/prio_arbiter_vectors.txt", vec_mem);
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_flag("reset_state", 1'b0, out_valid);
    check_mask("reset_state", '1, in_ready);  // Every slot empty
    @(posedge clk);
    p       = 0;
    running = 1'b1;
    while (running && p < VEC_DEPTH) begin
      kind = vec_mem[p];
      if ($isunknown(kind)) begin
        other_errors++;
        $display("vector file ends without an end record");
        running = 1'b0;
      end else begin
        case (kind)
          32'd0: running = 1'b0;
          32'd1: begin  // One cycle of stimulus
            new_mask   = vec_mem[p+1][`ARB_NUM_CH-1:0];
            ready_mode = vec_mem[p+2][1:0];
            for (int c = 0; c < `ARB_NUM_CH; c++) begin
              if (new_mask[c]) pend_q[c].push_back(vec_mem[p+3+c][`ARB_DATA_W-1:0]);
            end
            p = p + 3 + `ARB_NUM_CH;
            step_cycle();
          end
          32'd2: begin  // Expected output word
            exp_chan_q.push_back(vec_mem[p+1][CH_W-1:0]);
            exp_data_q.push_back(vec_mem[p+2][`ARB_DATA_W-1:0]);
            p = p + 3;
          end
          32'd3: begin  // Section end
            if (int'(vec_mem[p+1]) != sec_num) begin
              other_errors++;
              $display("vector section %0d found where %0d was due", vec_mem[p+1], sec_num);
            end
            drain_section(timed_out);
            if (timed_out) begin
              other_errors++;
              $display("%s: timed out waiting for the outputs", section_name(sec_num));
              running = 1'b0;
            end else begin
              compare_section(sec_num, int'(vec_mem[p+2]), int'(vec_mem[p+3]));
            end
            exp_data_q.delete();
            exp_chan_q.delete();
            got_data_q.delete();
            got_chan_q.delete();
            got_lat_q.delete();
            sec_num++;
            p = p + 4;
          end
          default: begin
            other_errors++;
            $display("unknown record kind %h in the vector file", kind);
            running = 1'b0;
          end
        endcase
      end
    end
    $display("Error counts: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/prio_arbiter_vectors.txt
// Hex records: 1 mask mode d0 d1 d2 d3 = new words for one cycle (mode 0 low, 1 high, 2 random)
// 2 chan data = expected output; 3 section order latency = end (order 0 per channel, 1 exact, 2 mirrored)

// Section 1, channel 2 alone, latency 2 edges
1 4 1 0 0 1201 0
1 4 1 0 0 1202 0
1 4 1 0 0 1203 0
1 0 1 0 0 0 0
1 4 1 0 0 1204 0
2 2 1201
2 2 1202
2 2 1203
2 2 1204
3 1 1 2

// Section 2, all channels at once
1 F 1 2000 2101 2202 2303
2 0 2000
2 1 2101
2 2 2202
2 3 2303
3 2 2 0

// Section 3, two channels at once
1 A 1 0 3101 0 3303
2 1 3101
2 3 3303
3 3 2 0

// Section 4, channel 0 streams and channel 3 waits
1 9 1 4000 0 0 4300
1 1 1 4001 0 0 0
1 1 1 4002 0 0 0
1 1 1 4003 0 0 0
1 0 1 0 0 0 0
2 0 4000
2 0 4001
2 0 4002
2 0 4003
2 3 4300
3 4 1 0

// Section 5, output stalled for five cycles
1 3 1 5000 5100 0 0
1 1 0 5001 0 0 0
1 2 0 0 5101 0 0
1 0 0 0 0 0 0
1 0 0 0 0 0 0
1 0 0 0 0 0 0
1 0 1 0 0 0 0
1 0 1 0 0 0 0
2 0 5000
2 0 5001
2 1 5100
2 1 5101
3 5 1 0

// Section 6, mixed traffic with random output ready
1 F 2 6000 6100 6200 6300
1 5 2 6001 0 6201 0
1 A 2 0 6101 0 6301
1 3 2 6002 6102 0 0
1 C 2 0 0 6202 6302
1 1 2 6003 0 0 0
1 8 2 0 0 0 6303
1 6 2 0 6103 6203 0
1 0 2 0 0 0 0
2 0 6000
2 0 6001
2 0 6002
2 0 6003
2 1 6100
2 1 6101
2 1 6102
2 1 6103
2 2 6200
2 2 6201
2 2 6202
2 2 6203
2 3 6300
2 3 6301
2 3 6302
2 3 6303
3 6 0 0
0

//--- prio_arbiter_top.f
+incdir+src
src/arb_pkg.sv
src/encoder.sv
src/priority_encoder.sv
src/chan_ingress.sv
src/egress_register.sv
src/prio_arbiter_top.sv
test/prio_arbiter_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
		-f prio_arbiter_top.f --top-module prio_arbiter_tb -o prio_arbiter_sim
	@out="$$(./obj_dir/prio_arbiter_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
